// File: hw/sifhPkg.sv
// sifh shared definitions
// widths, value types, default sizes and the pass encoding used by
// the two-pass time-of-flight histogram blocks
`default_nettype none

package sifhPkg;

    // ******************************
    // widths
    // ******************************
    // raw timestamp from the pixel front end
    localparam int TS_W         = 8;
    // coarse bin uses the upper bits of the timestamp
    localparam int BIN_W        = 6;
    localparam int BINS_PER_HIS = 64;
    // saturating count per bin
    localparam int CNT_W        = 8;
    // fine window spans 2 * HALF_WIN timestamps
    localparam int HALF_WIN     = 32;

    // ******************************
    // types
    // ******************************
    typedef logic [TS_W-1:0]  timestampT;
    typedef logic [BIN_W-1:0] binT;
    typedef logic [CNT_W-1:0] countT;

    // coarse pass first, then fine pass
    typedef enum logic [0:0] {
        COARSE_PASS = 1'b0,
        FINE_PASS   = 1'b1
    } passT;

    // default frame geometry
    localparam int DEF_PIXEL_NUM = 4;
    localparam int DEF_DATA_NUM  = 4;
    localparam int DEF_ACQ_NUM   = 8;

endpackage

`default_nettype wire

// File: hw/sampleIf.sv
// sample bus between front end and histogram tracker
// one filtered timestamp per cycle with its bin, pixel and pass tags
`default_nettype none

interface sampleIf #(
    parameter int pixelNum = sifhPkg::DEF_PIXEL_NUM
);
    import sifhPkg::*;

    localparam int PIX_W = (pixelNum > 1) ? $clog2(pixelNum) : 1;

    // valid and bin come from the filter
    logic             valid;
    binT              bin;
    // pixel, pass and end marker come from the sequencer
    logic [PIX_W-1:0] pixel;
    passT             pass;
    logic             lastOfPass;

    modport front   (output valid, bin, pixel, pass, lastOfPass);
    modport tracker (input valid, bin, pixel, pass, lastOfPass);

endinterface

`default_nettype wire

// File: hw/binAddressFilter.sv
// bin address filter
// coarse pass: upper timestamp bits become the bin
// fine pass: timestamp is checked against the pixel window and its
// offset from the window start becomes the bin
`default_nettype none

module binAddressFilter #(
    parameter int pixelNum = sifhPkg::DEF_PIXEL_NUM,
    localparam int PIX_W   = (pixelNum > 1) ? $clog2(pixelNum) : 1
) (
    input  logic               clk,
    input  logic               combin_res,
    input  logic               wrEn,
    input  sifhPkg::timestampT data,
    input  logic [PIX_W-1:0]   curPixel,
    input  sifhPkg::passT      curPass,
    input  sifhPkg::timestampT winLow [pixelNum],
    sampleIf.front             front
);
    import sifhPkg::*;

    // upper window bound relative to winLow
    localparam timestampT WIN_SPAN = timestampT'(2 * HALF_WIN - 1);

    timestampT winBase;
    timestampT winHigh;
    timestampT offset;
    logic      inWin;
    binT       binNext;

    // ******************************
    // window check and bin select
    // ******************************
    always_comb begin
        winBase = winLow[curPixel];
        // windows are clamped to 192 so this never wraps
        winHigh = winBase + WIN_SPAN;
        offset  = data - winBase;
        inWin   = (data >= winBase) && (data <= winHigh);

        if (curPass == COARSE_PASS) begin
            // drop the low bits
            binNext = data[TS_W-1 -: BIN_W];
        end else begin
            binNext = offset[BIN_W-1:0];
        end
    end

    // ******************************
    // sample register
    // ******************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            front.valid <= 1'b0;
        end else begin
            // out of window fine samples are discarded here
            front.valid <= wrEn && ((curPass == COARSE_PASS) || inWin);
        end
    end

    // bin is payload only, qualified by valid
    always_ff @(posedge clk) begin
        if (wrEn) begin
            front.bin <= binNext;
        end
    end

endmodule

`default_nettype wire

// File: hw/acqSequencer.sv
// acquisition sequencer
// counts accepted samples, pixels and acquisitions, toggles between the
// coarse and fine pass and holds busy while the pipeline drains
`default_nettype none

module acqSequencer #(
    parameter int pixelNum = sifhPkg::DEF_PIXEL_NUM,
    parameter int dataNum  = sifhPkg::DEF_DATA_NUM,
    parameter int acqNum   = sifhPkg::DEF_ACQ_NUM,
    localparam int PIX_W   = (pixelNum > 1) ? $clog2(pixelNum) : 1
) (
    input  logic             clk,
    input  logic             combin_res,
    input  logic             wrEn,
    output logic             busy,
    output logic [PIX_W-1:0] curPixel,
    output sifhPkg::passT    curPass,
    sampleIf.front           front
);
    import sifhPkg::*;

    localparam int SMP_W = (dataNum > 1) ? $clog2(dataNum) : 1;
    localparam int ACQ_W = (acqNum > 1) ? $clog2(acqNum) : 1;
    // busy spans filter, tracker and window update
    localparam int DRAIN_CYC = 3;

    logic [SMP_W-1:0] smpCnt;
    logic [PIX_W-1:0] pixCnt;
    logic [ACQ_W-1:0] acqCnt;
    passT             passState;
    logic [1:0]       drainCnt;

    logic accept;
    logic lastSmp;
    logic lastPix;
    logic lastAcq;
    logic passEnd;

    // wrEn during drain is dropped
    assign accept  = wrEn && !busy;
    assign lastSmp = (smpCnt == SMP_W'(dataNum - 1));
    assign lastPix = (pixCnt == PIX_W'(pixelNum - 1));
    assign lastAcq = (acqCnt == ACQ_W'(acqNum - 1));
    assign passEnd = accept && lastSmp && lastPix && lastAcq;

    assign curPixel = pixCnt;
    assign curPass  = passState;

    // ******************************
    // counters and pass state
    // ******************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            smpCnt    <= '0;
            pixCnt    <= '0;
            acqCnt    <= '0;
            passState <= COARSE_PASS;
        end else if (accept) begin
            smpCnt <= lastSmp ? '0 : smpCnt + 1'b1;
            // pixel steps after its dataNum samples
            if (lastSmp) begin
                pixCnt <= lastPix ? '0 : pixCnt + 1'b1;
                if (lastPix) begin
                    acqCnt <= lastAcq ? '0 : acqCnt + 1'b1;
                end
            end
            if (passEnd) begin
                passState <= (passState == COARSE_PASS) ? FINE_PASS : COARSE_PASS;
            end
        end
    end

    // ******************************
    // sample tags and drain window
    // ******************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            front.pixel      <= '0;
            front.pass       <= COARSE_PASS;
            front.lastOfPass <= 1'b0;
            busy             <= 1'b0;
            drainCnt         <= '0;
        end else begin
            // tags hold the last accepted sample, pass included
            if (accept) begin
                front.pixel <= pixCnt;
                front.pass  <= passState;
            end
            front.lastOfPass <= passEnd;

            if (passEnd) begin
                busy     <= 1'b1;
                drainCnt <= 2'(DRAIN_CYC - 1);
            end else if (busy) begin
                if (drainCnt == '0) begin
                    busy <= 1'b0;
                end else begin
                    drainCnt <= drainCnt - 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/histPeakTracker.sv
// histogram and peak tracker
// per-pixel bin counts in a register array with a valid bit per bin,
// saturating increment and a running peak per pixel, cleared between
// passes
`default_nettype none

module histPeakTracker #(
    parameter int pixelNum = sifhPkg::DEF_PIXEL_NUM
) (
    input  logic         clk,
    input  logic         combin_res,
    sampleIf.tracker     smp,
    output sifhPkg::binT peakBin [pixelNum],
    output logic         passDone
);
    import sifhPkg::*;

    localparam int PIX_W     = (pixelNum > 1) ? $clog2(pixelNum) : 1;
    localparam int BIN_TOTAL = pixelNum * BINS_PER_HIS;
    localparam countT CNT_MAX = '1;

    // ******************************
    // storage
    // ******************************
    countT                hisMem [BIN_TOTAL];
    // stale bins read as zero
    logic [BIN_TOTAL-1:0] binValid;
    countT                maxCnt [pixelNum];

    logic [PIX_W+BIN_W-1:0] addr;
    countT                  oldCnt;
    countT                  newCnt;

    // pixel selects the histogram, bin the entry inside it
    assign addr = {smp.pixel, smp.bin};

    // read-modify-write in one cycle
    always_comb begin
        oldCnt = binValid[addr] ? hisMem[addr] : '0;
        // hold at full scale
        if (oldCnt == CNT_MAX) begin
            newCnt = oldCnt;
        end else begin
            newCnt = oldCnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (smp.valid) begin
            hisMem[addr] <= newCnt;
        end
    end

    // ******************************
    // valid bits and peak search
    // ******************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binValid <= '0;
            passDone <= 1'b0;
            for (int i = 0; i < pixelNum; i++) begin
                maxCnt[i]  <= '0;
                peakBin[i] <= '0;
            end
        end else begin
            // last sample updates first, passDone follows
            passDone <= smp.lastOfPass;

            if (passDone) begin
                // peaks were taken by the window calc this cycle
                binValid <= '0;
                for (int i = 0; i < pixelNum; i++) begin
                    maxCnt[i]  <= '0;
                    peakBin[i] <= '0;
                end
            end else if (smp.valid) begin
                binValid[addr] <= 1'b1;
                // strictly greater, earlier bin wins ties
                if (newCnt > maxCnt[smp.pixel]) begin
                    maxCnt[smp.pixel]  <= newCnt;
                    peakBin[smp.pixel] <= smp.bin;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/windowCalc.sv
// window calculator
// after the coarse pass: peak bin -> clamped 64-wide fine window
// after the fine pass: window start plus fine peak -> timestamp estimate
`default_nettype none

module windowCalc #(
    parameter int pixelNum = sifhPkg::DEF_PIXEL_NUM
) (
    input  logic               clk,
    input  logic               combin_res,
    input  logic               passDone,
    input  sifhPkg::passT      curPass,
    input  sifhPkg::binT       peakBin [pixelNum],
    output sifhPkg::timestampT winLow [pixelNum],
    output sifhPkg::timestampT result [pixelNum],
    output logic               resultValid
);
    import sifhPkg::*;

    // highest legal window start, 255 - 63
    localparam timestampT WIN_TOP = timestampT'(2**TS_W - 2 * HALF_WIN);

    timestampT centre  [pixelNum];
    timestampT winNext [pixelNum];

    // ******************************
    // clamped window start
    // ******************************
    always_comb begin
        for (int i = 0; i < pixelNum; i++) begin
            // coarse bin back to timestamp scale
            centre[i] = timestampT'(peakBin[i]) << (TS_W - BIN_W);
            if (centre[i] <= timestampT'(HALF_WIN)) begin
                winNext[i] = '0;
            end else if (centre[i] > WIN_TOP - 1'b1) begin
                winNext[i] = WIN_TOP;
            end else begin
                winNext[i] = centre[i] - timestampT'(HALF_WIN);
            end
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            resultValid <= 1'b0;
            for (int i = 0; i < pixelNum; i++) begin
                winLow[i] <= '0;
                result[i] <= '0;
            end
        end else begin
            resultValid <= 1'b0;
            // curPass is the pass that just ended
            if (passDone && (curPass == COARSE_PASS)) begin
                for (int i = 0; i < pixelNum; i++) begin
                    winLow[i] <= winNext[i];
                end
            end else if (passDone) begin
                for (int i = 0; i < pixelNum; i++) begin
                    result[i] <= winLow[i] + timestampT'(peakBin[i]);
                end
                resultValid <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/sifhTop.sv
// sifh top level
// two-pass time-of-flight histogram for a small pixel group
// sequencer and filter share the input stream, the tracker builds the
// histograms, the window calc closes the loop back to the filter
`default_nettype none

module sifhTop #(
    parameter int pixelNum = sifhPkg::DEF_PIXEL_NUM,
    parameter int dataNum  = sifhPkg::DEF_DATA_NUM,
    parameter int acqNum   = sifhPkg::DEF_ACQ_NUM
) (
    input  logic                               clk,
    input  logic                               combin_res,
    input  logic                               wrEn,
    input  sifhPkg::timestampT                 data,
    output logic                               busy,
    output logic                               resultValid,
    output logic [pixelNum*sifhPkg::TS_W-1:0]  result
);
    import sifhPkg::*;

    localparam int PIX_W = (pixelNum > 1) ? $clog2(pixelNum) : 1;

    // ******************************
    // internal links
    // ******************************
    sampleIf #(.pixelNum(pixelNum)) smpBus ();

    logic [PIX_W-1:0] curPixel;
    passT             curPass;
    logic             acceptEn;
    logic             passDone;
    timestampT        winLow    [pixelNum];
    timestampT        resultArr [pixelNum];
    binT              peakBin   [pixelNum];

    // filter sees only samples the sequencer counts
    assign acceptEn = wrEn && !busy;

    acqSequencer #(
        .pixelNum(pixelNum),
        .dataNum (dataNum),
        .acqNum  (acqNum)
    ) uSeq (
        .clk       (clk),
        .combin_res(combin_res),
        .wrEn      (wrEn),
        .busy      (busy),
        .curPixel  (curPixel),
        .curPass   (curPass),
        .front     (smpBus.front)
    );

    binAddressFilter #(.pixelNum(pixelNum)) uFilter (
        .clk       (clk),
        .combin_res(combin_res),
        .wrEn      (acceptEn),
        .data      (data),
        .curPixel  (curPixel),
        .curPass   (curPass),
        .winLow    (winLow),
        .front     (smpBus.front)
    );

    histPeakTracker #(.pixelNum(pixelNum)) uTracker (
        .clk       (clk),
        .combin_res(combin_res),
        .smp       (smpBus.tracker),
        .peakBin   (peakBin),
        .passDone  (passDone)
    );

    // bus pass tag still names the pass that just finished
    windowCalc #(.pixelNum(pixelNum)) uWin (
        .clk        (clk),
        .combin_res (combin_res),
        .passDone   (passDone),
        .curPass    (smpBus.pass),
        .peakBin    (peakBin),
        .winLow     (winLow),
        .result     (resultArr),
        .resultValid(resultValid)
    );

    // pixel 0 in the low byte
    always_comb begin
        for (int i = 0; i < pixelNum; i++) begin
            result[i*TS_W +: TS_W] = resultArr[i];
        end
    end

endmodule

`default_nettype wire

// File: tests/sifhModel.svh
// reference model of the two-pass histogram
// coarse binning, clamped fine windows, fine binning and peak search
`ifndef SIFH_MODEL_SVH
`define SIFH_MODEL_SVH

// ******************************
// model state
// ******************************
int unsigned mHist [PIX_NUM][BINS_PER_HIS];
int unsigned mMax  [PIX_NUM];
int unsigned mPeak [PIX_NUM];
int unsigned mWin  [PIX_NUM];
int unsigned mEst  [PIX_NUM];
bit          mFine;

// histograms and peaks start empty each pass
task automatic clearHistograms();
    for (int i = 0; i < PIX_NUM; i++) begin
        for (int b = 0; b < BINS_PER_HIS; b++) begin
            mHist[i][b] = 0;
        end
        mMax[i]  = 0;
        mPeak[i] = 0;
    end
endtask

task automatic resetModel();
    mFine = 1'b0;
    for (int i = 0; i < PIX_NUM; i++) begin
        mWin[i] = 0;
        mEst[i] = 0;
    end
    clearHistograms();
endtask

// coarse peak to window start, clamped at both ends
function automatic int unsigned clampWindow(input int unsigned peak);
    int unsigned centre;
    centre = peak * (2 ** (TS_W - BIN_W));
    if (centre <= HALF_WIN) begin
        return 0;
    end else if (centre > 2 ** TS_W - 2 * HALF_WIN - 1) begin
        return 2 ** TS_W - 2 * HALF_WIN;
    end
    return centre - HALF_WIN;
endfunction

task automatic countSample(input int pix, input int unsigned t);
    int unsigned bin;
    if (!mFine) begin
        bin = t / (2 ** (TS_W - BIN_W));
    end else if ((t >= mWin[pix]) && (t < mWin[pix] + BINS_PER_HIS)) begin
        bin = t - mWin[pix];
    end else begin
        // outside the window, not counted
        return;
    end
    if (mHist[pix][bin] < 255) begin
        mHist[pix][bin]++;
    end
    // strictly greater, so the earlier bin keeps a tie
    if (mHist[pix][bin] > mMax[pix]) begin
        mMax[pix]  = mHist[pix][bin];
        mPeak[pix] = bin;
    end
endtask

// windows after coarse, estimates after fine
task automatic closePass();
    for (int i = 0; i < PIX_NUM; i++) begin
        if (!mFine) begin
            mWin[i] = clampWindow(mPeak[i]);
        end else begin
            mEst[i] = (mWin[i] + mPeak[i]) % (2 ** TS_W);
        end
    end
    mFine = !mFine;
    clearHistograms();
endtask

function automatic int unsigned expectedEstimate(input int pix);
    return mEst[pix];
endfunction

`endif

// File: tests/sifhTb.sv
// testbench for the two-pass histogram top level
// LFSR timestamp frames against the behavioral model, plus drain timing
`default_nettype none

module sifhTb;
    import sifhPkg::*;

    localparam int PIX_NUM     = DEF_PIXEL_NUM;
    localparam int DATA_NUM    = DEF_DATA_NUM;
    localparam int ACQ_NUM     = DEF_ACQ_NUM;
    localparam int DRAIN_LIMIT = 16;
    // stimulus shapes
    localparam int CLUSTER = 0;
    localparam int EDGES   = 1;
    localparam int STRAY   = 2;

    logic                    clk;
    logic                    combin_res;
    logic                    wrEn;
    timestampT               data;
    logic                    busy;
    logic                    resultValid;
    logic [PIX_NUM*TS_W-1:0] result;

    logic [31:0] lfsrState;
    int          errCnt;
    int          checkCnt;
    int          testCnt;
    int          badTests;
    int          errAtStart;

    `include "sifhModel.svh"

    sifhTop #(
        .pixelNum(PIX_NUM),
        .dataNum (DATA_NUM),
        .acqNum  (ACQ_NUM)
    ) UUT (
        .clk        (clk),
        .combin_res (combin_res),
        .wrEn       (wrEn),
        .data       (data),
        .busy       (busy),
        .resultValid(resultValid),
        .result     (result)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ******************************
    // helpers
    // ******************************
    // galois LFSR, one step per bit taken
    function automatic int unsigned randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsrState[0]};
            if (lfsrState[0]) begin
                lfsrState = (lfsrState >> 1) ^ 32'h8020_0003;
            end else begin
                lfsrState = lfsrState >> 1;
            end
        end
        return v;
    endfunction

    task automatic checkVal(input string what, input logic [31:0] exp, input logic [31:0] act);
        checkCnt++;
        assert (act === exp) else begin
            $display("[ERROR] %s expected %0d actual %0d", what, exp, act);
            errCnt++;
        end
    endtask

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("tests failed");
        $finish;
    endtask

    task automatic startTest();
        errAtStart = errCnt;
    endtask

    task automatic finishTest(input string name);
        testCnt++;
        if (errCnt == errAtStart) begin
            $display("test %s: ok", name);
        end else begin
            badTests++;
            $display("test %s: %0d errors", name, errCnt - errAtStart);
        end
    endtask

    // edge centres force both clamped windows
    function automatic timestampT pickCentre(input int mode, input int pix);
        if (mode == EDGES) begin
            return (pix % 2 == 0) ? timestampT'(4 + randBits(2)) : timestampT'(248 + randBits(2));
        end
        return timestampT'(randBits(TS_W));
    endfunction

    // spread of -4..+3 around the centre, strays only in the fine pass
    function automatic timestampT pickTs(input int mode, input bit finePass, input timestampT c);
        if ((mode == STRAY) && finePass && (randBits(2) == 0)) begin
            return timestampT'(randBits(TS_W));
        end
        return timestampT'(c + randBits(3) - 4);
    endfunction

    task automatic driveSample(input timestampT t, input bit gaps);
        if (gaps && (randBits(2) == 0)) begin
            @(negedge clk);
            wrEn = 1'b0;
        end
        @(negedge clk);
        wrEn = 1'b1;
        data = t;
    endtask

    // ******************************
    // pass drain and result check
    // ******************************
    task automatic drainPass(input string name, input bit finePass, input bit junk);
        int                      cnt;
        int                      busyCnt;
        int                      rvCnt;
        int                      rvAt;
        bit                      done;
        logic [PIX_NUM*TS_W-1:0] seen;
        cnt     = 0;
        busyCnt = 0;
        rvCnt   = 0;
        rvAt    = 0;
        done    = 1'b0;
        seen    = '0;
        while (!done) begin
            @(negedge clk);
            cnt++;
            if (resultValid) begin
                rvCnt++;
                rvAt = cnt;
                seen = result;
            end
            if (busy) begin
                busyCnt++;
                // dropped by the DUT, so not modeled
                wrEn = junk;
                if (junk) begin
                    data = timestampT'(randBits(TS_W));
                end
            end else begin
                wrEn = 1'b0;
                done = 1'b1;
            end
            if (!done && (cnt >= DRAIN_LIMIT)) begin
                abortRun("timeout: busy stayed high after the end of a pass");
            end
        end
        checkVal({name, " busy cycles"}, 3, busyCnt);
        checkVal({name, " resultValid pulses"}, finePass ? 1 : 0, rvCnt);
        if (finePass) begin
            checkVal({name, " resultValid delay"}, 3, rvAt);
            for (int i = 0; i < PIX_NUM; i++) begin
                checkVal($sformatf("%s pixel %0d", name, i), expectedEstimate(i),
                    seen[i*TS_W +: TS_W]);
            end
        end
    endtask

    // coarse pass then fine pass, same centres
    task automatic runFrame(input string name, input int mode, input bit gaps, input bit junk);
        timestampT centre [PIX_NUM];
        timestampT t;
        for (int i = 0; i < PIX_NUM; i++) begin
            centre[i] = pickCentre(mode, i);
        end
        for (int p = 0; p < 2; p++) begin
            for (int a = 0; a < ACQ_NUM; a++) begin
                for (int x = 0; x < PIX_NUM; x++) begin
                    for (int s = 0; s < DATA_NUM; s++) begin
                        t = pickTs(mode, p == 1, centre[x]);
                        driveSample(t, gaps);
                        countSample(x, t);
                    end
                end
            end
            closePass();
            drainPass(name, p == 1, junk);
        end
    endtask

    // ******************************
    // test sequence
    // ******************************
    initial begin
        lfsrState  = 32'h3fea;
        errCnt     = 0;
        checkCnt   = 0;
        testCnt    = 0;
        badTests   = 0;
        errAtStart = 0;
        combin_res = 1'b0;
        wrEn       = 1'b0;
        data       = '0;
        resetModel();
        repeat (8) @(negedge clk);
        combin_res = 1'b1;

        startTest();
        @(negedge clk);
        checkVal("reset busy", 0, busy);
        checkVal("reset resultValid", 0, resultValid);
        checkVal("reset result", 0, result);
        finishTest("reset values");

        startTest();
        runFrame("clustered", CLUSTER, 1'b0, 1'b0);
        finishTest("clustered frame");

        startTest();
        runFrame("clamping", EDGES, 1'b0, 1'b0);
        finishTest("window clamping");

        startTest();
        runFrame("stray", STRAY, 1'b0, 1'b0);
        finishTest("out-of-window samples");

        startTest();
        runFrame("busy", CLUSTER, 1'b0, 1'b1);
        finishTest("ignored input while busy");

        // no reset between frames
        startTest();
        runFrame("frame a", STRAY, 1'b1, 1'b0);
        runFrame("frame b", CLUSTER, 1'b0, 1'b0);
        runFrame("frame c", EDGES, 1'b1, 1'b1);
        finishTest("back-to-back frames");

        $display("summary: %0d tests, %0d ok, %0d with errors, %0d checks, %0d errors",
            testCnt, testCnt - badTests, badTests, checkCnt, errCnt);
        if (errCnt == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+tests
hw/sifhPkg.sv
hw/sampleIf.sv
hw/binAddressFilter.sv
hw/acqSequencer.sv
hw/histPeakTracker.sv
hw/windowCalc.sv
hw/sifhTop.sv
tests/sifhTb.sv

// File: Bender.yml
package:
  name: sifh

sources:
  - files:
      - hw/sifhPkg.sv
      - hw/sampleIf.sv
      - hw/binAddressFilter.sv
      - hw/acqSequencer.sv
      - hw/histPeakTracker.sv
      - hw/windowCalc.sv
      - hw/sifhTop.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/sifhTb.sv
